/* src/pocket_pkg.sv */
// shared types and constants for the debug key block, referenced by scoped name from each file
`default_nettype none

package pocket;

    // direction of one cartridge bank as seen from the core
    typedef enum logic {
        DIR_IN  = 1'b0,
        DIR_OUT = 1'b1
    } port_dir_t;

    // frame phase, shared by the transmitter and the receiver
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } uart_state_t;

    // APB register map, byte addresses on a 4-bit paddr
    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,
        REG_STATUS = 4'h4,
        REG_TXDATA = 4'h8,
        REG_RXDATA = 4'hC
    } reg_addr_t;

    // status register bit positions

    // debounced button level, live
    localparam int STAT_BUTTON   = 0;

    // sticky flag for any debounced button edge, write 1 to clear
    localparam int STAT_BTN_CHG  = 1;

    // transmitter still sending a frame
    localparam int STAT_TX_BUSY  = 2;

    // a received byte waits in RXDATA
    localparam int STAT_RX_VALID = 3;

    // a byte arrived before the previous one was read
    localparam int STAT_OVERRUN  = 4;

endpackage

`default_nettype wire

/* src/cart_ifs.sv */
// cartridge bank and debug key bundles that connect the pin mapping to the top level
`timescale 1ns/1ps
`default_nettype none

// one 8-bit cartridge bank with split in, out and direction
interface port_if;
    logic [7:0]        data_out;
    logic [7:0]        data_in;
    pocket::port_dir_t dir;

    // core side picks the direction and drives the outgoing byte
    modport core (
        output dir,
        output data_out,
        input  data_in
    );

    // pad side samples what the core drives and returns the pins
    modport pad (
        input  dir,
        input  data_out,
        output data_in
    );
endinterface

// signals that reach the debug key through the cartridge port
interface debug_key_if;
    logic led;
    logic button;
    logic uart_tx;
    logic uart_rx;

    // pin mapping side
    modport key (
        input  led,
        input  uart_tx,
        output button,
        output uart_rx
    );

    // register and UART side
    modport host (
        output led,
        output uart_tx,
        input  button,
        input  uart_rx
    );
endinterface

`default_nettype wire

/* src/debug_key.sv */
// maps LED, UART and button onto cartridge banks, instantiated once by the top level
`timescale 1ns/1ps
`default_nettype none

module debug_key #(
    parameter int debounce_cycles = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    port_if.core        bank0,
    port_if.core        bank3,
    port_if.core        pin31,
    debug_key_if.key    key
);

    // counter wide enough to reach debounce_cycles - 1
    localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;

    logic             btn_meta;
    logic             btn_sync;
    logic             btn_state;
    logic [cnt_w-1:0] btn_cnt;
    logic             rx_meta;
    logic             rx_sync;

    always_comb begin
        // bank0 carries the outputs
        bank0.dir      = pocket::DIR_OUT;
        // bit 6 is TX, bit 5 is LED, everything else held low
        bank0.data_out = {1'b0, key.uart_tx, key.led, 5'b0_0000};
        // button and RX come in on bank3 and pin31
        bank3.dir      = pocket::DIR_IN;
        bank3.data_out = 8'h00;
        pin31.dir      = pocket::DIR_IN;
        pin31.data_out = 8'h00;
    end

    // button pin is active low, so flip before the synchronizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_meta  <= 1'b0;
            btn_sync  <= 1'b0;
            btn_state <= 1'b0;
            btn_cnt   <= '0;
        end else begin
            btn_meta <= ~bank3.data_in[0];
            btn_sync <= btn_meta;
            if (btn_sync == btn_state) begin
                // input agrees with the held level, restart the count
                btn_cnt <= '0;
            end else if (btn_cnt == cnt_w'(debounce_cycles - 1)) begin
                btn_state <= btn_sync;
                btn_cnt   <= '0;
            end else begin
                btn_cnt <= btn_cnt + 1'b1;
            end
        end
    end

    // RX idles high so the synchronizer resets high too
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= pin31.data_in[0];
            rx_sync <= rx_meta;
        end
    end

    assign key.button  = btn_state;
    assign key.uart_rx = rx_sync;

endmodule

`default_nettype wire

/* src/uart_tx.sv */
// 8N1 serial transmitter, started by a one-cycle tx_start from the register block
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_busy,
    output logic       tx_line
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    pocket::uart_state_t state;
    logic [cnt_w-1:0]    cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift;
    logic                bit_done;

    // last cycle of the current bit time
    assign bit_done = (cnt == cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= pocket::IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;
        end else begin
            case (state)
                pocket::IDLE: begin
                    cnt     <= '0;
                    tx_line <= 1'b1;
                    if (tx_start) begin
                        // start bit goes out on the next cycle
                        state   <= pocket::START;
                        tx_line <= 1'b0;
                    end
                end
                pocket::START: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        state   <= pocket::DATA;
                        bit_idx <= '0;
                        tx_line <= shift[0];
                    end
                end
                pocket::DATA: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state   <= pocket::STOP;
                            tx_line <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_line <= shift[0];
                        end
                    end
                end
                default: begin
                    // stop bit, line already high
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        state <= pocket::IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first, shift right as each bit is handed to the line
    always_ff @(posedge clk) begin
        if (state == pocket::IDLE && tx_start) begin
            shift <= tx_data;
        end else if (bit_done && (state == pocket::START || state == pocket::DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    assign tx_busy = (state != pocket::IDLE);

endmodule

`default_nettype wire

/* src/uart_rx.sv */
// 8N1 serial receiver, fed by the synchronized RX pin and read through the register block
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_line,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    // offset from the falling edge to the middle of the start bit
    localparam int half = (clks_per_bit > 1) ? clks_per_bit / 2 : 1;

    pocket::uart_state_t state;
    logic [cnt_w-1:0]    cnt;
    logic [2:0]          bit_idx;
    logic [7:0]          shift;
    logic                rx_q;
    logic                fall;
    logic                bit_done;

    // falling edge on the line
    assign fall     = rx_q & ~rx_line;
    // sample point, every full bit time after mid start
    assign bit_done = (cnt == cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= pocket::IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_q     <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            rx_q     <= rx_line;
            // single cycle pulse
            rx_valid <= 1'b0;
            case (state)
                pocket::IDLE: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= pocket::START;
                    end
                end
                pocket::START: begin
                    if (cnt == cnt_w'(half - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // line back high means a glitch, not a start bit
                        state   <= rx_line ? pocket::IDLE : pocket::DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                pocket::DATA: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state <= pocket::STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    cnt <= bit_done ? '0 : cnt + 1'b1;
                    if (bit_done) begin
                        // mid stop bit, a low line drops the frame
                        state    <= pocket::IDLE;
                        rx_valid <= rx_line;
                    end
                end
            endcase
        end
    end

    // data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == pocket::DATA && bit_done) begin
            shift <= {rx_line, shift[7:1]};
        end
    end

    // byte only moves out on a good stop bit
    always_ff @(posedge clk) begin
        if (state == pocket::STOP && bit_done && rx_line) begin
            rx_byte <= shift;
        end
    end

endmodule

`default_nettype wire

/* src/debug_regs.sv */
// APB register block for the debug key, host access to LED, status, TX and RX
`timescale 1ns/1ps
`default_nettype none

module debug_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic        tx_busy,
    input  logic        rx_valid,
    input  logic [7:0]  rx_byte,
    input  logic        button,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        led,
    output logic        tx_start,
    output logic [7:0]  tx_data
);

    pocket::reg_addr_t addr;
    logic              access;
    logic              wr;
    logic              rd;
    logic              err;
    logic              tx_busy_any;
    logic              led_q;
    logic              btn_prev;
    logic              btn_chg;
    logic              rx_full;
    logic              overrun;

    assign addr   = pocket::reg_addr_t'(paddr);
    // access phase of a transfer, always zero wait
    assign access = psel & penable;
    assign wr     = access & pwrite;
    assign rd     = access & ~pwrite;
    assign pready = 1'b1;

    // covers the cycle between accepting a byte and the transmitter going busy
    assign tx_busy_any = tx_busy | tx_start;

    always_comb begin
        prdata = 32'h0000_0000;
        err    = 1'b0;
        case (addr)
            pocket::REG_CTRL: begin
                prdata[0] = led_q;
            end
            pocket::REG_STATUS: begin
                prdata[pocket::STAT_BUTTON]   = button;
                prdata[pocket::STAT_BTN_CHG]  = btn_chg;
                prdata[pocket::STAT_TX_BUSY]  = tx_busy_any;
                prdata[pocket::STAT_RX_VALID] = rx_full;
                prdata[pocket::STAT_OVERRUN]  = overrun;
            end
            pocket::REG_TXDATA: begin
                // write only, refused while a frame is in flight
                err = pwrite & tx_busy_any;
            end
            pocket::REG_RXDATA: begin
                prdata[7:0] = rx_byte;
                err         = pwrite;
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

    assign pslverr = access & err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led_q    <= 1'b0;
            tx_start <= 1'b0;
            btn_prev <= 1'b0;
            btn_chg  <= 1'b0;
            rx_full  <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            tx_start <= wr && addr == pocket::REG_TXDATA && !tx_busy_any;
            btn_prev <= button;
            if (wr && addr == pocket::REG_CTRL) begin
                led_q <= pwdata[0];
            end
            // a new edge wins over a clear in the same cycle
            if (button != btn_prev) begin
                btn_chg <= 1'b1;
            end else if (wr && addr == pocket::REG_STATUS && pwdata[pocket::STAT_BTN_CHG]) begin
                btn_chg <= 1'b0;
            end
            if (rx_valid) begin
                rx_full <= 1'b1;
            end else if (rd && addr == pocket::REG_RXDATA) begin
                rx_full <= 1'b0;
            end
            // previous byte still unread when the next one lands
            if (rx_valid && rx_full) begin
                overrun <= 1'b1;
            end else if (wr && addr == pocket::REG_STATUS && pwdata[pocket::STAT_OVERRUN]) begin
                overrun <= 1'b0;
            end
        end
    end

    // byte handed to the transmitter with the start pulse
    always_ff @(posedge clk) begin
        if (wr && addr == pocket::REG_TXDATA && !tx_busy_any) begin
            tx_data <= pwdata[7:0];
        end
    end

    assign led = led_q;

endmodule

`default_nettype wire

/* src/debug_key_top.sv */
// debug key subsystem top level, APB slave on one side and cartridge pins on the other
`timescale 1ns/1ps
`default_nettype none

module debug_key_top #(
    parameter int clks_per_bit    = 16,
    parameter int debounce_cycles = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic [7:0]        bank0_data_out,
    output pocket::port_dir_t bank0_dir,
    input  logic [7:0]        bank3_data_in,
    output pocket::port_dir_t bank3_dir,
    input  logic              pin31_data_in,
    output pocket::port_dir_t pin31_dir
);

    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       rx_valid;
    logic [7:0] rx_byte;

    port_if      bank0 ();
    port_if      bank3 ();
    port_if      pin31 ();
    debug_key_if key_bus ();

    // pad side of the three banks
    assign bank0_data_out = bank0.data_out;
    assign bank0_dir      = bank0.dir;
    // bank0 is output only, nothing comes back
    assign bank0.data_in  = 8'h00;
    assign bank3.data_in  = bank3_data_in;
    assign bank3_dir      = bank3.dir;
    // pin31 is a single pin on bit 0
    assign pin31.data_in  = {7'b000_0000, pin31_data_in};
    assign pin31_dir      = pin31.dir;

    debug_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .tx_busy  (tx_busy),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .button   (key_bus.button),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .led      (key_bus.led),
        .tx_start (tx_start),
        .tx_data  (tx_data)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .tx_line  (key_bus.uart_tx)
    );

    uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (key_bus.uart_rx),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    debug_key #(.debounce_cycles(debounce_cycles)) u_key (
        .clk   (clk),
        .rst_n (rst_n),
        .bank0 (bank0),
        .bank3 (bank3),
        .pin31 (pin31),
        .key   (key_bus)
    );

endmodule

`default_nettype wire

/* sim/tb_debug_key.sv */
// top-level testbench that replays the golden steps on debug_key_top and checks its responses
`timescale 1ns/1ps
`default_nettype none

module tb_debug_key;

    localparam int clk_period      = 100;
    localparam int clks_per_bit    = 16;
    localparam int debounce_cycles = 32;
    localparam int frame_cycles    = 10 * clks_per_bit;

    logic              clk;
    logic              rst_n;
    logic [3:0]        paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic [7:0]        bank0_data_out;
    pocket::port_dir_t bank0_dir;
    logic [7:0]        bank3_data_in;
    pocket::port_dir_t bank3_dir;
    logic              pin31_data_in;
    pocket::port_dir_t pin31_dir;

    // golden steps with one entry per data line
    logic [63:0] step_op[$];
    logic [31:0] step_addr[$];
    logic [31:0] step_data[$];
    logic [31:0] step_exp[$];
    logic [31:0] step_err[$];

    logic [31:0] lcg_state;
    logic [7:0]  last_rx;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    debug_key_top #(
        .clks_per_bit    (clks_per_bit),
        .debounce_cycles (debounce_cycles)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .bank0_data_out (bank0_data_out),
        .bank0_dir      (bank0_dir),
        .bank3_data_in  (bank3_data_in),
        .bank3_dir      (bank3_dir),
        .pin31_data_in  (pin31_data_in),
        .pin31_dir      (pin31_dir)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog that arms once the golden file is loaded
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            report_error($sformatf("run timed out after %0d cycles", cycle_count));
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) report_error($sformatf("Fail %s: got %08h expected %08h", name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) report_error($sformatf("Fail %s: got %02h expected %02h", name, got, exp));
    endtask

    task automatic check_dir(input string name, input pocket::port_dir_t got,
                             input pocket::port_dir_t exp);
        if (got !== exp) report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    // LCG step whose top byte has the best period
    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    // one zero-wait APB transfer with outputs sampled a quarter period into the access phase
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);
        rdata = prdata;
        err   = pslverr;
        check_bit("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_bit("pslverr", err, exp_err);
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        check_data("prdata", rdata, exp);
        check_bit("pslverr", err, exp_err);
    endtask

    // poll STATUS until one bit reaches the wanted level
    task automatic wait_status(input int pos, input logic level, input string what);
        logic [31:0] rdata;
        logic        err;
        int          tries;
        tries = 0;
        apb_xfer(1'b0, pocket::REG_STATUS, 32'h0, rdata, err);
        while (rdata[pos] !== level) begin
            if (tries == 4 * clks_per_bit) report_error(what);
            tries++;
            apb_xfer(1'b0, pocket::REG_STATUS, 32'h0, rdata, err);
        end
    endtask

    // serial receiver on bank0 bit 6 that samples near mid-bit
    task automatic capture_frame(output logic [7:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (bank0_data_out[6] !== 1'b0) begin
            if (waited == 4 * clks_per_bit) report_error("no start bit seen on the TX pin");
            waited++;
            @(negedge clk);
        end
        repeat (clks_per_bit / 2) @(negedge clk);
        check_bit("tx start bit", bank0_data_out[6], 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = bank0_data_out[6];
        end
        repeat (clks_per_bit) @(negedge clk);
        check_bit("tx stop bit", bank0_data_out[6], 1'b1);
    endtask

    // serial driver on pin31 sending LSB first with one idle bit after the stop bit
    task automatic drive_frame(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            pin31_data_in = frame[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        // receiver latency ends inside this idle bit
        repeat (clks_per_bit) @(negedge clk);
    endtask

    // random byte out and a refused second write while the frame runs
    task automatic tx_frame(input logic [3:0] addr, input int delay, input logic exp_err);
        logic [7:0] sent;
        logic [7:0] seen;
        sent = rand_byte();
        apb_write(addr, {24'h0, sent}, 1'b0);
        fork
            capture_frame(seen);
            begin
                repeat (delay) @(negedge clk);
                wait_status(pocket::STAT_TX_BUSY, 1'b1, "tx_busy low during a frame");
                apb_write(addr, {24'h0, ~sent}, exp_err);
            end
        join
        check_byte("tx frame", seen, sent);
        wait_status(pocket::STAT_TX_BUSY, 1'b0, "tx_busy stayed high after the frame");
    endtask

    task automatic send_frame();
        last_rx = rand_byte();
        drive_frame(last_rx);
        wait_status(pocket::STAT_RX_VALID, 1'b1, "rx_valid never set after a serial frame");
    endtask

    // button pin is active low
    task automatic hold_button(input logic level, input int cycles);
        @(negedge clk);
        bank3_data_in[0] = level;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic load_golden();
        int               fd;
        int               n;
        logic [8*160-1:0] line_buf;
        logic [63:0]      op;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [31:0]      e;
        logic [31:0]      r;
        fd = $fopen("sim/debug_key_golden.txt", "r");
        if (fd == 0) report_error("cannot open the golden file sim/debug_key_golden.txt");
        while (!$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            n = $sscanf(line_buf, "%s %h %h %h %h", op, a, d, e, r);
            // comment and blank lines never give five fields
            if (n == 5 && op != "#") begin
                step_op.push_back(op);
                step_addr.push_back(a);
                step_data.push_back(d);
                step_exp.push_back(e);
                step_err.push_back(r);
            end
        end
        $fclose(fd);
        if (step_op.size() == 0) report_error("the golden file holds no steps");
    endtask

    task automatic run_step(input int i);
        logic [31:0] rdata;
        logic        err;
        case (step_op[i])
            "write":   apb_write(step_addr[i][3:0], step_data[i], step_err[i][0]);
            "read":    apb_read(step_addr[i][3:0], step_exp[i], step_err[i][0]);
            "led":     check_bit("bank0_data_out[5]", bank0_data_out[5], step_exp[i][0]);
            "txframe": tx_frame(step_addr[i][3:0], step_data[i], step_err[i][0]);
            "send":    send_frame();
            "press":   hold_button(1'b0, step_data[i]);
            "release": hold_button(1'b1, step_data[i]);
            "rxdata": begin
                apb_xfer(1'b0, pocket::REG_RXDATA, 32'h0, rdata, err);
                check_byte("rx byte", rdata[7:0], last_rx);
                check_bit("pslverr", err, 1'b0);
            end
            default:   report_error($sformatf("unknown op on golden step %0d", i));
        endcase
    endtask

    initial begin
        rst_n         = 1'b0;
        paddr         = 4'h0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = 32'h0;
        bank3_data_in = 8'hFF;
        pin31_data_in = 1'b1;
        lcg_state     = 32'h4982_87b0;
        load_golden();
        // no step needs more than twelve frames
        cycle_limit = step_op.size() * 12 * frame_cycles + 1000;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_dir("bank0_dir", bank0_dir, pocket::DIR_OUT);
        check_dir("bank3_dir", bank3_dir, pocket::DIR_IN);
        check_dir("pin31_dir", pin31_dir, pocket::DIR_IN);
        // TX idles high with LED and spare bits low
        check_byte("bank0_data_out", bank0_data_out, 8'h40);
        foreach (step_op[i]) begin
            run_step(i);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/debug_key_golden.txt */
# columns: op, paddr, write data or cycle count, expected read value, expected pslverr (all hex)
# txframe retries the write after the given cycles, press and release hold the button pin
read    4 00000000 00000000 0
write   0 00000001 00000000 0
led     0 00000000 00000001 0
read    0 00000000 00000001 0
write   0 00000000 00000000 0
led     0 00000000 00000000 0
read    0 00000000 00000000 0
txframe 8 00000030 00000000 1
read    4 00000000 00000000 0
send    c 00000000 00000000 0
read    4 00000000 00000008 0
rxdata  c 00000000 00000000 0
read    4 00000000 00000000 0
send    c 00000000 00000000 0
send    c 00000000 00000000 0
read    4 00000000 00000018 0
write   4 00000010 00000000 0
read    4 00000000 00000008 0
rxdata  c 00000000 00000000 0
read    4 00000000 00000000 0
write   2 00000000 00000000 1
read    6 00000000 00000000 1
write   c 00000000 00000000 1
press   0 0000000a 00000000 0
release 0 00000040 00000000 0
read    4 00000000 00000000 0
press   0 00000040 00000000 0
read    4 00000000 00000003 0
write   4 00000002 00000000 0
read    4 00000000 00000001 0
release 0 00000040 00000000 0
read    4 00000000 00000002 0
write   4 00000002 00000000 0
read    4 00000000 00000000 0

/* flist.f */
src/pocket_pkg.sv
src/cart_ifs.sv
src/debug_key.sv
src/uart_tx.sv
src/uart_rx.sv
src/debug_regs.sv
src/debug_key_top.sv
sim/tb_debug_key.sv
